//--- Makefile
# Verilator build and run of the I2C master testbench.
VERILATOR ?= verilator
TOP       ?= tb_i2c_master
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@echo "Result: PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- i2c_bus_pkg.sv
package i2c_bus_pkg;

	// Clock cycles per quarter of an SCL bit period.
	localparam int QTR_CYCLES = 4;

	// Width of the quarter-bit divider counter.
	localparam int QTR_CNT_W = $clog2(QTR_CYCLES);

	// Quarters of one bit.
	// SCL is held low in Q0 and Q1 and released in Q2 and Q3.
	typedef enum logic [1:0] {
		PH_Q0 = 2'd0,
		PH_Q1 = 2'd1,
		PH_Q2 = 2'd2,
		PH_Q3 = 2'd3
	} bit_phase_t;

	// Open-drain requests.
	// A set bit pulls the line low; a clear bit leaves it to the pull-up.
	typedef struct packed {
		logic scl_low;
		logic sda_low;
	} line_drv_t;

endpackage

//--- i2c_cmd_if.sv
`timescale 1ns/10ps

module i2c_cmd_if import i2c_host_pkg::*; (
	input  logic              clk_i,
	input  logic              rst,
	input  logic              sel_i,
	input  logic              enable_i,
	input  logic              write_i,
	input  logic [ADDR_W-1:0] addr_i,
	input  logic [DATA_W-1:0] wdata_i,
	input  logic              done_i,
	output logic              ready_o,
	output logic              cmd_valid_o,
	output i2c_cmd_t          cmd_o
);

	logic accept;

	// Setup phase seen while idle.
	assign accept = sel_i && !enable_i && ready_o;

	always_ff @(posedge clk_i) begin
		if (rst) begin
			ready_o     <= 1'b1;
			cmd_valid_o <= 1'b0;
		end else begin
			cmd_valid_o <= accept;
			if (accept) begin
				ready_o <= 1'b0;
			end else if (done_i) begin
				ready_o <= 1'b1;
			end
		end
	end

	// Command stays put until the next accepted setup phase.
	always_ff @(posedge clk_i) begin
		if (accept) begin
			cmd_o.rw    <= ~write_i;
			cmd_o.addr  <= addr_i;
			cmd_o.wdata <= wdata_i;
		end
	end

endmodule

//--- i2c_host_pkg.sv
package i2c_host_pkg;

	// Target address and data byte widths.
	localparam int ADDR_W = 7;
	localparam int DATA_W = 8;

	// One host command.
	// Bit rw set means a read from the target.
	typedef struct packed {
		logic              rw;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} i2c_cmd_t;

	// Result of one transaction, valid with the done pulse.
	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic              addr_nack;
		logic              data_nack;
	} i2c_rsp_t;

	// Sequencer states.
	// Every state except idle lasts a whole number of bit periods.
	typedef enum logic [3:0] {
		ST_IDLE     = 4'd0,
		ST_START    = 4'd1,
		ST_ADDR     = 4'd2,
		ST_ACK_ADDR = 4'd3,
		ST_WDATA    = 4'd4,
		ST_ACK_DATA = 4'd5,
		ST_RDATA    = 4'd6,
		ST_MACK     = 4'd7,
		ST_STOP     = 4'd8
	} ctl_state_t;

endpackage

//--- i2c_line_io.sv
`timescale 1ns/10ps

module i2c_line_io import i2c_bus_pkg::*; (
	input  logic      clk_i,
	input  logic      rst,
	input  line_drv_t drv_i,
	input  logic      sda_i,
	output logic      scl_oe_o,
	output logic      sda_oe_o,
	output logic      sda_sync_o
);

	logic sda_meta_q;

	// Pin drivers straight from flops.
	always_ff @(posedge clk_i) begin
		if (rst) begin
			scl_oe_o <= 1'b0;
			sda_oe_o <= 1'b0;
		end else begin
			scl_oe_o <= drv_i.scl_low;
			sda_oe_o <= drv_i.sda_low;
		end
	end

	// Two-stage synchronizer, idles at the pulled-up level.
	always_ff @(posedge clk_i) begin
		if (rst) begin
			sda_meta_q <= 1'b1;
			sda_sync_o <= 1'b1;
		end else begin
			sda_meta_q <= sda_i;
			sda_sync_o <= sda_meta_q;
		end
	end

endmodule

//--- i2c_master_fsm.sv
`timescale 1ns/10ps

module i2c_master_fsm import i2c_bus_pkg::*, i2c_host_pkg::*; (
	input  logic       clk_i,
	input  logic       rst,
	input  logic       cmd_valid_i,
	input  i2c_cmd_t   cmd_i,
	input  logic       qtick_i,
	input  bit_phase_t phase_i,
	input  logic       sda_sync_i,
	output logic       run_o,
	output line_drv_t  drv_o,
	output logic       done_o,
	output i2c_rsp_t   rsp_o
);

	ctl_state_t        state_q;
	ctl_state_t        state_d;
	logic [2:0]        bit_cnt_q;
	logic [DATA_W-1:0] tx_q;
	logic [DATA_W-1:0] rx_q;
	logic [DATA_W-1:0] wdata_q;
	logic              rw_q;
	logic              sda_low_q;
	logic              sda_q0_d;
	logic              addr_nack_q;
	logic              data_nack_q;
	logic              start_cmd;
	logic              tick_q0;
	logic              tick_q2;
	logic              tick_q3;
	logic              shift_state;

	assign start_cmd = cmd_valid_i && (state_q == ST_IDLE);
	assign tick_q0   = qtick_i && (phase_i == PH_Q0);
	assign tick_q2   = qtick_i && (phase_i == PH_Q2);
	assign tick_q3   = qtick_i && (phase_i == PH_Q3);

	assign shift_state = (state_q == ST_ADDR) || (state_q == ST_WDATA)
		|| (state_q == ST_RDATA);

	always_comb begin
		state_d = state_q;
		if (state_q == ST_IDLE) begin
			if (cmd_valid_i)
				state_d = ST_START;
		end else if (tick_q3) begin
			case (state_q)
				ST_START:    state_d = ST_ADDR;
				ST_ADDR:     state_d = (bit_cnt_q == 3'd0) ? ST_ACK_ADDR : ST_ADDR;
				ST_ACK_ADDR: begin
					// No acknowledge, so the data byte is skipped.
					if (addr_nack_q)
						state_d = ST_STOP;
					else if (rw_q)
						state_d = ST_RDATA;
					else
						state_d = ST_WDATA;
				end
				ST_WDATA:    state_d = (bit_cnt_q == 3'd0) ? ST_ACK_DATA : ST_WDATA;
				ST_ACK_DATA: state_d = ST_STOP;
				ST_RDATA:    state_d = (bit_cnt_q == 3'd0) ? ST_MACK : ST_RDATA;
				ST_MACK:     state_d = ST_STOP;
				default:     state_d = ST_IDLE;
			endcase
		end
	end

	// SDA level taken at the end of Q0, while SCL is low.
	// Acknowledge slots, read bits and the master NACK leave SDA released.
	always_comb begin
		case (state_q)
			ST_START, ST_STOP: sda_q0_d = 1'b1;
			ST_ADDR, ST_WDATA: sda_q0_d = ~tx_q[DATA_W-1];
			default:           sda_q0_d = 1'b0;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst) begin
			state_q     <= ST_IDLE;
			sda_low_q   <= 1'b0;
			done_o      <= 1'b0;
			bit_cnt_q   <= 3'd7;
			addr_nack_q <= 1'b0;
			data_nack_q <= 1'b0;
		end else begin
			state_q <= state_d;
			done_o  <= tick_q3 && (state_q == ST_STOP);
			if (tick_q0) begin
				sda_low_q <= sda_q0_d;
			end else if (tick_q2 && (state_q == ST_STOP)) begin
				sda_low_q <= 1'b0;
			end
			if (start_cmd) begin
				bit_cnt_q   <= 3'd7;
				addr_nack_q <= 1'b0;
				data_nack_q <= 1'b0;
			end else begin
				// Wraps back to 7 after the last bit of a byte.
				if (tick_q3 && shift_state)
					bit_cnt_q <= bit_cnt_q - 3'd1;
				if (tick_q2 && (state_q == ST_ACK_ADDR))
					addr_nack_q <= sda_sync_i;
				if (tick_q2 && (state_q == ST_ACK_DATA))
					data_nack_q <= sda_sync_i;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (start_cmd) begin
			tx_q    <= {cmd_i.addr, cmd_i.rw};
			wdata_q <= cmd_i.wdata;
			rw_q    <= cmd_i.rw;
			rx_q    <= '0;
		end else begin
			if (tick_q0 && ((state_q == ST_ADDR) || (state_q == ST_WDATA)))
				tx_q <= {tx_q[DATA_W-2:0], 1'b0};
			else if (tick_q3 && (state_q == ST_ACK_ADDR))
				tx_q <= wdata_q;
			// MSB arrives first.
			if (tick_q2 && (state_q == ST_RDATA))
				rx_q <= {rx_q[DATA_W-2:0], sda_sync_i};
		end
	end

	assign run_o = (state_q != ST_IDLE);

	// SCL stays released through the whole START bit.
	assign drv_o.scl_low = run_o && (state_q != ST_START)
		&& ((phase_i == PH_Q0) || (phase_i == PH_Q1));
	assign drv_o.sda_low = sda_low_q;

	assign rsp_o.rdata     = rx_q;
	assign rsp_o.addr_nack = addr_nack_q;
	assign rsp_o.data_nack = data_nack_q;

endmodule

//--- i2c_master_top.sv
`timescale 1ns/10ps

module i2c_master_top import i2c_bus_pkg::*, i2c_host_pkg::*; (
	input  logic              clk_i,
	input  logic              rst,
	input  logic              sel_i,
	input  logic              enable_i,
	input  logic              write_i,
	input  logic [ADDR_W-1:0] addr_i,
	input  logic [DATA_W-1:0] wdata_i,
	input  logic              sda_i,
	output logic [DATA_W-1:0] rdata_o,
	output logic              addr_nack_o,
	output logic              data_nack_o,
	output logic              ready_o,
	output logic              done_o,
	output logic              scl_oe_o,
	output logic              sda_oe_o
);

	logic       cmd_valid;
	i2c_cmd_t   cmd;
	logic       run;
	logic       qtick;
	bit_phase_t phase;
	line_drv_t  drv;
	logic       sda_sync;
	i2c_rsp_t   rsp;

	i2c_cmd_if u_cmd_if (
		.clk_i       (clk_i),
		.rst         (rst),
		.sel_i       (sel_i),
		.enable_i    (enable_i),
		.write_i     (write_i),
		.addr_i      (addr_i),
		.wdata_i     (wdata_i),
		.done_i      (done_o),
		.ready_o     (ready_o),
		.cmd_valid_o (cmd_valid),
		.cmd_o       (cmd)
	);

	i2c_scl_gen u_scl_gen (
		.clk_i   (clk_i),
		.rst     (rst),
		.run_i   (run),
		.qtick_o (qtick),
		.phase_o (phase)
	);

	i2c_master_fsm u_fsm (
		.clk_i       (clk_i),
		.rst         (rst),
		.cmd_valid_i (cmd_valid),
		.cmd_i       (cmd),
		.qtick_i     (qtick),
		.phase_i     (phase),
		.sda_sync_i  (sda_sync),
		.run_o       (run),
		.drv_o       (drv),
		.done_o      (done_o),
		.rsp_o       (rsp)
	);

	i2c_line_io u_line_io (
		.clk_i      (clk_i),
		.rst        (rst),
		.drv_i      (drv),
		.sda_i      (sda_i),
		.scl_oe_o   (scl_oe_o),
		.sda_oe_o   (sda_oe_o),
		.sda_sync_o (sda_sync)
	);

	assign rdata_o     = rsp.rdata;
	assign addr_nack_o = rsp.addr_nack;
	assign data_nack_o = rsp.data_nack;

endmodule

//--- i2c_scl_gen.sv
`timescale 1ns/10ps

module i2c_scl_gen import i2c_bus_pkg::*; (
	input  logic       clk_i,
	input  logic       rst,
	input  logic       run_i,
	output logic       qtick_o,
	output bit_phase_t phase_o
);

	logic [QTR_CNT_W-1:0] cnt_q;
	bit_phase_t           phase_q;

	// Last cycle of the current quarter.
	// The counter sits at zero while stopped, so no tick leaks out.
	assign qtick_o = (cnt_q == QTR_CNT_W'(QTR_CYCLES - 1));
	assign phase_o = phase_q;

	always_ff @(posedge clk_i) begin
		if (rst || !run_i) begin
			cnt_q   <= '0;
			phase_q <= PH_Q0;
		end else if (qtick_o) begin
			cnt_q   <= '0;
			phase_q <= bit_phase_t'(phase_q + 2'd1);
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

endmodule

//--- i2c_tests.txt
// rw addr wdata tgt_addr dack rbyte exp_rdata exp_addr_nack exp_data_nack
// hex fields; rw 1 = read, dack 1 = target acknowledges the write byte
0 50 a5 50 1 00 00 0 0
1 50 00 50 1 3c 3c 0 0
0 21 5a 22 1 00 00 1 0
0 7f 81 7f 0 00 00 0 1
1 0a ff 0a 1 c3 c3 0 0
1 12 00 13 1 77 00 1 0
0 00 00 00 1 00 00 0 0
0 2b ff 2b 1 00 00 0 0
1 55 00 55 1 01 01 0 0
1 66 00 66 1 80 80 0 0
0 3c 00 3c 0 00 00 0 1

//--- tb.f
i2c_bus_pkg.sv
i2c_host_pkg.sv
i2c_cmd_if.sv
i2c_scl_gen.sv
i2c_master_fsm.sv
i2c_line_io.sv
i2c_master_top.sv
tb_i2c_assertions.sv
tb_i2c_master.sv

//--- tb_i2c_assertions.sv
`timescale 1ns/10ps

module tb_i2c_assertions (
	input logic clk_i,
	input logic rst,
	input logic sel_i,
	input logic enable_i,
	input logic ready_o,
	input logic done_o,
	input logic scl_oe_o,
	input logic sda_oe_o
);

	int unsigned fail_cnt = 0;
	logic        in_flight;

	// Set from acceptance until the done pulse.
	always @(posedge clk_i) begin
		if (rst)
			in_flight <= 1'b0;
		else if (sel_i && !enable_i && ready_o)
			in_flight <= 1'b1;
		else if (done_o)
			in_flight <= 1'b0;
	end

	done_one_cycle: assert property (@(posedge clk_i) disable iff (rst) done_o |=> !done_o)
		else begin
			$error("done_o held for more than one cycle");
			fail_cnt++;
		end

	ready_low_busy: assert property (@(posedge clk_i) disable iff (rst) in_flight |-> !ready_o)
		else begin
			$error("ready_o high while a transaction runs");
			fail_cnt++;
		end

	lines_free_after_reset: assert property (@(posedge clk_i) rst |=> (!scl_oe_o && !sda_oe_o))
		else begin
			$error("Open-drain enables active after reset");
			fail_cnt++;
		end

endmodule

bind i2c_master_top tb_i2c_assertions u_assertions (
	.clk_i    (clk_i),
	.rst      (rst),
	.sel_i    (sel_i),
	.enable_i (enable_i),
	.ready_o  (ready_o),
	.done_o   (done_o),
	.scl_oe_o (scl_oe_o),
	.sda_oe_o (sda_oe_o)
);

//--- tb_i2c_master.sv
`timescale 1ns/10ps

module tb_i2c_master import i2c_bus_pkg::*, i2c_host_pkg::*; ();

	localparam int MAX_LINES = 32;
	localparam int FIELDS    = 9;
	// Full 20-bit transaction plus slack, in ns.
	localparam int LINE_NS   = 20 * 4 * QTR_CYCLES * 10 + 200;

	logic              clk_i;
	logic              rst;
	logic              sel;
	logic              enable;
	logic              write;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] rdata;
	logic              addr_nack;
	logic              data_nack;
	logic              ready;
	logic              done;
	logic              scl_oe;
	logic              sda_oe;
	logic              scl;
	logic              sda;
	logic              tgt_sda_low;
	logic              in_frame;
	logic              addr_ok;
	logic              mack_level;
	logic [7:0]        addr_sh;
	logic [7:0]        data_sh;
	logic [6:0]        tgt_addr;
	logic              tgt_dack;
	logic [7:0]        tgt_rbyte;
	int                bit_idx;
	int                starts;
	int                stops;
	int                num_lines;
	bit                tests_loaded;
	logic [15:0]       vec_mem [0:MAX_LINES*FIELDS-1];

	// Wired-AND bus with pull-ups.
	assign scl = ~scl_oe;
	assign sda = ~(sda_oe | tgt_sda_low);

	i2c_master_top dut (
		.clk_i       (clk_i),
		.rst         (rst),
		.sel_i       (sel),
		.enable_i    (enable),
		.write_i     (write),
		.addr_i      (addr),
		.wdata_i     (wdata),
		.sda_i       (sda),
		.rdata_o     (rdata),
		.addr_nack_o (addr_nack),
		.data_nack_o (data_nack),
		.ready_o     (ready),
		.done_o      (done),
		.scl_oe_o    (scl_oe),
		.sda_oe_o    (sda_oe)
	);

	always #5 clk_i = ~clk_i;

	// START and STOP are SDA edges while SCL is high.
	always @(negedge sda) begin
		if (scl === 1'b1) begin
			starts    = starts + 1;
			in_frame  = 1'b1;
			bit_idx   = 0;
			addr_ok   = 1'b0;
		end
	end

	always @(posedge sda) begin
		if (scl === 1'b1) begin
			stops    = stops + 1;
			in_frame = 1'b0;
		end
	end

	// Target samples on rising SCL.
	always @(posedge scl) begin
		if (in_frame) begin
			if (bit_idx < 8) begin
				addr_sh = {addr_sh[6:0], sda};
			end else if (bit_idx >= 9 && bit_idx <= 16 && addr_ok && !addr_sh[0]) begin
				data_sh = {data_sh[6:0], sda};
			end else if (bit_idx == 17 && addr_ok && addr_sh[0]) begin
				mack_level = sda;
			end
			bit_idx = bit_idx + 1;
		end
	end

	// Target drives SDA only while SCL is low.
	always @(negedge scl) begin : tgt_drive
		logic drive;
		drive = 1'b0;
		if (in_frame) begin
			if (bit_idx == 8) begin
				addr_ok = (addr_sh[7:1] == tgt_addr);
				drive   = addr_ok;
			end else if (bit_idx >= 9 && bit_idx <= 16 && addr_ok && addr_sh[0]) begin
				drive = ~tgt_rbyte[16 - bit_idx];
			end else if (bit_idx == 17 && addr_ok && !addr_sh[0]) begin
				drive = tgt_dack;
			end
		end
		tgt_sda_low = drive;
	end

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("Verification failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_rsp(input i2c_rsp_t got, input i2c_rsp_t exp);
		if (got !== exp)
			abort_run($sformatf("Fail at %0t: rsp expected %h got %h", $time, exp, got));
	endtask

	task automatic check_bus_byte(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("Fail at %0t: %s expected %h got %h", $time, name, exp, got));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("Fail at %0t: %s expected %b got %b", $time, name, exp, got));
	endtask

	initial begin : main
		int       i;
		int       n;
		int       base;
		int       starts_before;
		int       stops_before;
		logic     rd;
		i2c_rsp_t exp_rsp;
		i2c_rsp_t got_rsp;
		clk_i        = 1'b0;
		rst          = 1'b1;
		sel          = 1'b0;
		enable       = 1'b0;
		write        = 1'b0;
		addr         = '0;
		wdata        = '0;
		tgt_sda_low  = 1'b0;
		in_frame     = 1'b0;
		addr_ok      = 1'b0;
		mack_level   = 1'b0;
		starts       = 0;
		stops        = 0;
		tests_loaded = 1'b0;
		void'($urandom(33956));
		// Unloaded entries keep bit 15 set.
		for (i = 0; i < MAX_LINES * FIELDS; i++)
			vec_mem[i] = 16'h8000 | 16'(i);
		$readmemh("i2c_tests.txt", vec_mem);
		num_lines = 0;
		while (num_lines < MAX_LINES && !vec_mem[num_lines * FIELDS][15])
			num_lines++;
		if (num_lines == 0)
			abort_run("No test lines found in i2c_tests.txt");
		tests_loaded = 1'b1;
		repeat (3) @(posedge clk_i);
		rst <= 1'b0;
		@(posedge clk_i);
		check_bit("ready_o", ready, 1'b1);
		check_bit("scl", scl, 1'b1);
		check_bit("sda", sda, 1'b1);
		for (n = 0; n < num_lines; n++) begin
			base      = n * FIELDS;
			rd        = vec_mem[base][0];
			tgt_addr  = vec_mem[base+3][6:0];
			tgt_dack  = vec_mem[base+4][0];
			tgt_rbyte = vec_mem[base+5][7:0];
			exp_rsp.rdata     = vec_mem[base+6][7:0];
			exp_rsp.addr_nack = vec_mem[base+7][0];
			exp_rsp.data_nack = vec_mem[base+8][0];
			repeat ($urandom_range(20, 0)) @(posedge clk_i);
			while (!ready)
				@(posedge clk_i);
			starts_before = starts;
			stops_before  = stops;
			sel    <= 1'b1;
			write  <= ~rd;
			addr   <= vec_mem[base+1][6:0];
			wdata  <= vec_mem[base+2][7:0];
			@(posedge clk_i);
			enable <= 1'b1;
			@(posedge clk_i);
			sel    <= 1'b0;
			enable <= 1'b0;
			// A second command while busy is dropped.
			repeat (3) @(posedge clk_i);
			check_bit("ready_o", ready, 1'b0);
			sel   <= 1'b1;
			write <= rd;
			addr  <= ~vec_mem[base+1][6:0];
			wdata <= ~vec_mem[base+2][7:0];
			@(posedge clk_i);
			sel <= 1'b0;
			while (!done)
				@(posedge clk_i);
			got_rsp.rdata     = rdata;
			got_rsp.addr_nack = addr_nack;
			got_rsp.data_nack = data_nack;
			check_rsp(got_rsp, exp_rsp);
			if (starts != starts_before + 1 || stops != stops_before + 1)
				abort_run("Target did not see exactly one START and one STOP");
			check_bus_byte("target address byte", addr_sh, {vec_mem[base+1][6:0], rd});
			// Nine SCL pulses per byte and acknowledge, one more in the STOP bit.
			if (bit_idx != (exp_rsp.addr_nack ? 10 : 19))
				abort_run("Target saw the wrong number of SCL pulses in the transaction");
			if (addr_ok && !rd)
				check_bus_byte("target data byte", data_sh, vec_mem[base+2][7:0]);
			if (addr_ok && rd)
				check_bit("master ack level", mack_level, 1'b1);
		end
		@(posedge clk_i);
		if (dut.u_assertions.fail_cnt == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin : watchdog
		wait (tests_loaded);
		#(num_lines * LINE_NS + 100);
		$display("Timeout: the test lines did not finish in time");
		$display("Verification failed");
		$fatal(1, "Watchdog expired");
	end

endmodule
